/* verilog/rename_pkg.sv */
// Rename stage widths, sizes, instruction, free-register pair and dispatch entry types
`default_nettype none

package rename_pkg;

    // Group width, instructions renamed per cycle
    localparam int ss = 2;

    // Register number widths
    localparam int arch_bits = 5;
    localparam int preg_count = 64;
    localparam int preg_bits = 6;

    // ROB sizing
    localparam int rob_depth = 8;
    localparam int rob_bits = 3;

    // Queue depths, in groups and in pairs
    localparam int iq_depth = 4;
    localparam int fl_depth = 16;

    // One decoded instruction from the front end
    typedef struct packed {
        logic valid;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [arch_bits-1:0] rs1;
        logic [arch_bits-1:0] rs2;
        logic [arch_bits-1:0] rd;
        // Operand taken from immediate or pc instead of the register file
        logic use_imm1;
        logic use_imm2;
    } inst_info_t;

    // Instruction queue payload
    typedef inst_info_t [ss-1:0] inst_group_t;

    // Free list payload, one new destination per slot
    typedef logic [ss-1:0][preg_bits-1:0] preg_pair_t;

    // Renamed instruction for the reservation station and ROB
    typedef struct packed {
        logic [rob_bits-1:0] rob_id;
        logic [preg_bits-1:0] prs1;
        logic [preg_bits-1:0] prs2;
        logic [preg_bits-1:0] prd;
        logic rs1_ready;
        logic rs2_ready;
        // Producer ROB ids of the source operands
        logic [rob_bits-1:0] rs1_source;
        logic [rob_bits-1:0] rs2_source;
        inst_info_t info;
    } dispatch_entry_t;

endpackage : rename_pkg

`default_nettype wire

/* verilog/rename_if.sv */
// Interfaces rat_if and preg_status_if with requester and table modports
`timescale 1ns/10ps
`default_nettype none

// Register alias table lookup and update
interface rat_if;
    import rename_pkg::*;

    // Architectural sources and destination per slot
    logic [arch_bits-1:0] rs1 [ss];
    logic [arch_bits-1:0] rs2 [ss];
    logic [arch_bits-1:0] rd [ss];
    // New physical destination, written on rename
    logic [preg_bits-1:0] prd [ss];
    logic rename;
    // Mapped physical sources
    logic [preg_bits-1:0] prs1 [ss];
    logic [preg_bits-1:0] prs2 [ss];

    modport requester (output rs1, rs2, rd, prd, rename, input prs1, prs2);
    modport tbl (input rs1, rs2, rd, prd, rename, output prs1, prs2);
endinterface : rat_if

// Physical register busy status lookup and set
interface preg_status_if;
    import rename_pkg::*;

    logic [preg_bits-1:0] prs1 [ss];
    logic [preg_bits-1:0] prs2 [ss];
    logic [preg_bits-1:0] prd [ss];
    logic [rob_bits-1:0] rob_id [ss];
    // Slot writes a real destination, not x0
    logic rd_valid [ss];
    logic set;
    // Status of each source
    logic rs1_busy [ss];
    logic rs2_busy [ss];
    logic [rob_bits-1:0] rs1_src [ss];
    logic [rob_bits-1:0] rs2_src [ss];

    modport requester (output prs1, prs2, prd, rob_id, rd_valid, set,
                       input rs1_busy, rs2_busy, rs1_src, rs2_src);
    modport tbl (input prs1, prs2, prd, rob_id, rd_valid, set,
                 output rs1_busy, rs2_busy, rs1_src, rs2_src);
endinterface : preg_status_if

`default_nettype wire

/* verilog/sync_fifo.sv */
// Synchronous circular-buffer FIFO with a payload type parameter
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int depth = 4
) (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input payload_t din,
    output payload_t dout,
    output logic full,
    output logic empty
);

    // Storage, pointers wrap naturally for power-of-two depths
    payload_t mem [depth];
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth):0] count;
    logic do_push;
    logic do_pop;

    // Push into a full buffer is dropped
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    assign full = (count == ($clog2(depth)+1)'(depth));
    assign empty = (count == '0);

    // Head entry is always visible
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy tracks the net change
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : sync_fifo

`default_nettype wire

/* verilog/rename_table.sv */
// Register alias table with per-slot lookup, paired update and intra-group bypass
`timescale 1ns/10ps
`default_nettype none

module rename_table (
    input logic clk,
    input logic rst,
    rat_if.tbl rat
);
    import rename_pkg::*;

    // Architectural to physical mapping
    logic [preg_bits-1:0] map [2**arch_bits];

    // Update on the rename strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map out of reset
            for (int i = 0; i < 2**arch_bits; i++) begin
                map[i] <= preg_bits'(i);
            end
        end else if (rat.rename) begin
            // Later slot overwrites an earlier one on the same rd
            for (int s = 0; s < ss; s++) begin
                // x0 stays bound to physical register 0
                if (rat.rd[s] != '0) begin
                    map[rat.rd[s]] <= rat.prd[s];
                end
            end
        end
    end

    // Lookup sees the table before this group's writes
    always_comb begin
        for (int s = 0; s < ss; s++) begin
            rat.prs1[s] = map[rat.rs1[s]];
            rat.prs2[s] = map[rat.rs2[s]];
            // Older slots in the group rename first, the nearest one wins
            for (int j = 0; j < s; j++) begin
                if (rat.rd[j] != '0 && rat.rd[j] == rat.rs1[s]) begin
                    rat.prs1[s] = rat.prd[j];
                end
                if (rat.rd[j] != '0 && rat.rd[j] == rat.rs2[s]) begin
                    rat.prs2[s] = rat.prd[j];
                end
            end
        end
    end

endmodule : rename_table

`default_nettype wire

/* verilog/preg_status.sv */
// Physical register busy bits and producer ROB ids with writeback clear
`timescale 1ns/10ps
`default_nettype none

module preg_status (
    input logic clk,
    input logic rst,
    input logic wb_valid,
    input logic [rename_pkg::preg_bits-1:0] wb_preg,
    preg_status_if.tbl st
);
    import rename_pkg::*;

    // One busy bit per physical register
    logic [preg_count-1:0] busy;
    // ROB id of the last dispatched writer
    logic [rob_bits-1:0] producer [preg_count];

    // Busy bits, a set overrides a clear at the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_preg] <= 1'b0;
            end
            if (st.set) begin
                for (int s = 0; s < ss; s++) begin
                    if (st.rd_valid[s]) begin
                        busy[st.prd[s]] <= 1'b1;
                    end
                end
            end
        end
    end

    // Producer ids follow the busy set
    always_ff @(posedge clk) begin
        if (st.set) begin
            for (int s = 0; s < ss; s++) begin
                if (st.rd_valid[s]) begin
                    producer[st.prd[s]] <= st.rob_id[s];
                end
            end
        end
    end

    // Lookup from registered state
    always_comb begin
        for (int s = 0; s < ss; s++) begin
            // Physical register 0 backs x0 and is never busy
            st.rs1_busy[s] = busy[st.prs1[s]] && (st.prs1[s] != '0);
            st.rs2_busy[s] = busy[st.prs2[s]] && (st.prs2[s] != '0);
            st.rs1_src[s] = producer[st.prs1[s]];
            st.rs2_src[s] = producer[st.prs2[s]];
            // Dependency on an older slot of the same group
            for (int j = 0; j < s; j++) begin
                if (st.rd_valid[j] && st.prd[j] == st.prs1[s]) begin
                    st.rs1_busy[s] = 1'b1;
                    st.rs1_src[s] = st.rob_id[j];
                end
                if (st.rd_valid[j] && st.prd[j] == st.prs2[s]) begin
                    st.rs2_busy[s] = 1'b1;
                    st.rs2_src[s] = st.rob_id[j];
                end
            end
        end
    end

endmodule : preg_status

`default_nettype wire

/* verilog/rob_id_alloc.sv */
// ROB id allocator handing out id pairs and tracking occupancy
`timescale 1ns/10ps
`default_nettype none

module rob_id_alloc (
    input logic clk,
    input logic rst,
    input logic alloc,
    input logic rob_free,
    output logic [rename_pkg::rob_bits-1:0] rob_ids [rename_pkg::ss],
    output logic room
);
    import rename_pkg::*;

    logic [rob_bits-1:0] next_id;
    // One extra bit so a full ROB is representable
    logic [rob_bits:0] count;
    logic [rob_bits:0] add;
    logic [rob_bits:0] sub;

    // Whole group per alloc, one entry per free
    assign add = alloc ? (rob_bits+1)'(ss) : '0;
    // Ignore a free with nothing outstanding
    assign sub = (rob_free && count != '0) ? (rob_bits+1)'(1) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                next_id <= next_id + rob_bits'(ss);
            end
            count <= count + add - sub;
        end
    end

    // Consecutive ids, wrapping with the ROB
    always_comb begin
        for (int s = 0; s < ss; s++) begin
            rob_ids[s] = next_id + rob_bits'(s);
        end
    end

    // Enough free entries for a full group
    assign room = (count <= (rob_bits+1)'(rob_depth - ss));

endmodule : rob_id_alloc

`default_nettype wire

/* verilog/dispatcher.sv */
// Dispatcher with pop decision, rename requests, operand readiness and entry register
`timescale 1ns/10ps
`default_nettype none

module dispatcher (
    input logic clk,
    input logic rst,
    input logic rs_full,
    input logic iq_empty,
    input logic fl_empty,
    input logic room,
    input rename_pkg::inst_group_t group,
    input rename_pkg::preg_pair_t free_pregs,
    input logic [rename_pkg::rob_bits-1:0] rob_ids [rename_pkg::ss],
    rat_if.requester rat,
    preg_status_if.requester st,
    output logic pop,
    output logic entry_valid,
    output rename_pkg::dispatch_entry_t entry [rename_pkg::ss]
);
    import rename_pkg::*;

    dispatch_entry_t next_entry [ss];

    // Group, free registers and ROB ids all available and RS can accept
    assign pop = !rs_full && !iq_empty && !fl_empty && room;

    // Same strobe renames, marks busy and allocates
    assign rat.rename = pop;
    assign st.set = pop;

    // RAT requests straight from the queue head
    always_comb begin
        for (int s = 0; s < ss; s++) begin
            rat.rs1[s] = group[s].rs1;
            rat.rs2[s] = group[s].rs2;
            rat.rd[s] = group[s].rd;
            rat.prd[s] = free_pregs[s];
        end
    end

    // Status lookups on the mapped sources
    always_comb begin
        for (int s = 0; s < ss; s++) begin
            st.prs1[s] = rat.prs1[s];
            st.prs2[s] = rat.prs2[s];
            st.prd[s] = free_pregs[s];
            st.rob_id[s] = rob_ids[s];
            // x0 destination consumes a register but marks nothing
            st.rd_valid[s] = (group[s].rd != '0);
        end
    end

    // Build the entries
    always_comb begin
        for (int s = 0; s < ss; s++) begin
            next_entry[s].rob_id = rob_ids[s];
            next_entry[s].prs1 = rat.prs1[s];
            next_entry[s].prs2 = rat.prs2[s];
            next_entry[s].prd = free_pregs[s];
            // Immediate or pc operand needs no producer
            next_entry[s].rs1_ready = group[s].use_imm1 || !st.rs1_busy[s];
            next_entry[s].rs2_ready = group[s].use_imm2 || !st.rs2_busy[s];
            next_entry[s].rs1_source = st.rs1_src[s];
            next_entry[s].rs2_source = st.rs2_src[s];
            next_entry[s].info = group[s];
        end
    end

    // Valid follows pop by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= 1'b0;
        end else begin
            entry_valid <= pop;
        end
    end

    // Entry holds under back-pressure
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int s = 0; s < ss; s++) begin
                entry[s] <= next_entry[s];
            end
        end
    end

endmodule : dispatcher

`default_nettype wire

/* verilog/rename_dispatch_top.sv */
// Rename and dispatch top level with instruction queue, free list, RAT, status and ROB ids
`timescale 1ns/10ps
`default_nettype none

module rename_dispatch_top (
    input logic clk,
    input logic rst,
    input logic inst_push,
    input logic free_push,
    input logic rs_full,
    input logic wb_valid,
    input logic rob_free,
    input rename_pkg::inst_group_t inst_group,
    input rename_pkg::preg_pair_t free_pair,
    input logic [rename_pkg::preg_bits-1:0] wb_preg,
    output logic iq_full,
    output logic entry_valid,
    output rename_pkg::dispatch_entry_t entry [rename_pkg::ss]
);
    import rename_pkg::*;

    logic pop;
    logic iq_empty;
    logic fl_empty;
    logic room;
    inst_group_t head_group;
    preg_pair_t free_pregs;
    logic [rob_bits-1:0] rob_ids [ss];

    rat_if rat_bus ();
    preg_status_if status_bus ();

    // Decoded groups waiting for rename
    sync_fifo #(
        .payload_t(inst_group_t),
        .depth(iq_depth)
    ) inst_queue_i (
        .clk(clk),
        .rst(rst),
        .push(inst_push),
        .pop(pop),
        .din(inst_group),
        .dout(head_group),
        .full(iq_full),
        .empty(iq_empty)
    );

    // Free physical registers, refilled by retirement
    sync_fifo #(
        .payload_t(preg_pair_t),
        .depth(fl_depth)
    ) free_list_i (
        .clk(clk),
        .rst(rst),
        .push(free_push),
        .pop(pop),
        .din(free_pair),
        .dout(free_pregs),
        .full(),
        .empty(fl_empty)
    );

    rename_table rename_table_i (
        .clk(clk),
        .rst(rst),
        .rat(rat_bus.tbl)
    );

    preg_status preg_status_i (
        .clk(clk),
        .rst(rst),
        .wb_valid(wb_valid),
        .wb_preg(wb_preg),
        .st(status_bus.tbl)
    );

    rob_id_alloc rob_id_alloc_i (
        .clk(clk),
        .rst(rst),
        .alloc(pop),
        .rob_free(rob_free),
        .rob_ids(rob_ids),
        .room(room)
    );

    dispatcher dispatcher_i (
        .clk(clk),
        .rst(rst),
        .rs_full(rs_full),
        .iq_empty(iq_empty),
        .fl_empty(fl_empty),
        .room(room),
        .group(head_group),
        .free_pregs(free_pregs),
        .rob_ids(rob_ids),
        .rat(rat_bus.requester),
        .st(status_bus.requester),
        .pop(pop),
        .entry_valid(entry_valid),
        .entry(entry)
    );

endmodule : rename_dispatch_top

`default_nettype wire

/* testbench/rename_dispatch_assertions.sv */
// Concurrent assertions on the rename and dispatch top-level ports, bound to the top level
`timescale 1ns/10ps
`default_nettype none

module rename_dispatch_assertions (
    input logic clk,
    input logic rst,
    input logic entry_valid,
    input rename_pkg::dispatch_entry_t entry [rename_pkg::ss]
);
    import rename_pkg::*;

    // Nothing leaves the stage while reset is applied
    property valid_low_in_reset;
        @(posedge clk) $past(rst) |-> !entry_valid;
    endproperty

    // Physical register 0 backs x0 and is never handed out
    property prd_not_zero;
        @(posedge clk) disable iff (rst)
            entry_valid |-> (entry[0].prd != '0) && (entry[1].prd != '0);
    endproperty

    // Slot ids follow each other around the ROB
    property rob_ids_consecutive;
        @(posedge clk) disable iff (rst)
            entry_valid |-> entry[1].rob_id == rob_bits'(entry[0].rob_id + 1'b1);
    endproperty

    valid_low_in_reset_a: assert property (valid_low_in_reset)
        else $error("entry_valid is high during reset");

    prd_not_zero_a: assert property (prd_not_zero)
        else $error("a dispatch entry carries physical destination 0");

    rob_ids_consecutive_a: assert property (rob_ids_consecutive)
        else $error("ROB ids of the two slots are not consecutive");

endmodule : rename_dispatch_assertions

bind rename_dispatch_top rename_dispatch_assertions assertions_i (
    .clk(clk),
    .rst(rst),
    .entry_valid(entry_valid),
    .entry(entry)
);

`default_nettype wire

/* testbench/rename_dispatch_tb.sv */
// Testbench for the rename and dispatch stage with reference model, stimulus, checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module rename_dispatch_tb;
    import rename_pkg::*;

    localparam int reset_cycles = 16;
    localparam int group_total = 60;
    // About fifty cycles per group, stalls included
    localparam int watchdog_cycles = 50 * (group_total + 20);

    logic clk;
    logic rst;
    logic inst_push;
    logic free_push;
    logic rs_full;
    logic wb_valid;
    logic rob_free;
    inst_group_t inst_group;
    preg_pair_t free_pair;
    logic [preg_bits-1:0] wb_preg;
    logic iq_full;
    logic entry_valid;
    dispatch_entry_t entry [ss];

    // Reference model
    logic [preg_bits-1:0] ref_map [32];
    logic [preg_bits-1:0] ref_free [$];
    logic ref_busy [preg_count];
    logic [rob_bits-1:0] ref_producer [preg_count];
    logic [rob_bits-1:0] ref_rob_id;
    inst_group_t sent [$];
    // Writeback seen last cycle, sampled by the DUT on the coming edge
    logic last_wb_valid;
    logic [preg_bits-1:0] last_wb_preg;
    // Push seen last cycle, and the instruction queue occupancy it leads to
    logic last_inst_push;
    int iq_count;

    // Stimulus control
    logic [31:0] rng;
    int groups_sent;
    int entries_seen;
    int inst_target;
    int fill_next;
    int cycle_count;
    logic fill_on;
    logic recycle_on;
    logic random_on;

    rename_dispatch_top dut_i (
        .clk(clk),
        .rst(rst),
        .inst_push(inst_push),
        .free_push(free_push),
        .rs_full(rs_full),
        .wb_valid(wb_valid),
        .rob_free(rob_free),
        .inst_group(inst_group),
        .free_pair(free_pair),
        .wb_preg(wb_preg),
        .iq_full(iq_full),
        .entry_valid(entry_valid),
        .entry(entry)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw(input logic [31:0] range);
        rng = xorshift(rng);
        return rng % range;
    endfunction

    function automatic inst_group_t make_group();
        inst_group_t g;
        for (int s = 0; s < ss; s++) begin
            g[s].valid = 1'b1;
            g[s].inst = draw(32'hffff_ffff);
            g[s].pc = 32'h0000_1000 + 32'(groups_sent * 8 + s * 4);
            // Roughly one register in six is x0
            g[s].rd = (draw(6) == 0) ? '0 : arch_bits'(draw(32));
            g[s].rs1 = (draw(6) == 0) ? '0 : arch_bits'(draw(32));
            g[s].rs2 = (draw(6) == 0) ? '0 : arch_bits'(draw(32));
            g[s].use_imm1 = (draw(4) == 0);
            g[s].use_imm2 = (draw(3) == 0);
        end
        // Slot 1 now and then reads what slot 0 writes
        if (draw(4) == 0) begin
            g[1].rs1 = g[0].rd;
        end
        if (draw(4) == 0) begin
            g[1].rs2 = g[0].rd;
        end
        return g;
    endfunction

    // Neither mapped nor waiting in the free list
    function automatic logic is_unused(input logic [preg_bits-1:0] p);
        foreach (ref_map[i]) begin
            if (ref_map[i] == p) begin
                return 1'b0;
            end
        end
        foreach (ref_free[i]) begin
            if (ref_free[i] == p) begin
                return 1'b0;
            end
        end
        return p != '0;
    endfunction

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        assert (expected === actual) else begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "check %s mismatched", name);
        end
    endtask

    task automatic stop_with(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "%s", reason);
    endtask

    // Compare a dispatched group with the model, then apply it and the last writeback
    task automatic track_outputs();
        inst_group_t g;
        logic [preg_bits-1:0] prs1;
        logic [preg_bits-1:0] prs2;
        logic [preg_bits-1:0] prd [ss];
        logic [preg_count-1:0] set_now;
        set_now = '0;
        if (rst) begin
            if (cycle_count > 0) begin
                check("reset entry_valid", 0, entry_valid);
            end
        end else if (entry_valid && (sent.size() == 0 || ref_free.size() < ss)) begin
            stop_with("An entry appeared with no pushed group or free registers behind it");
        end else if (entry_valid) begin
            g = sent.pop_front();
            // Slot order, so slot 1 sees slot 0's rename and wins a shared rd
            for (int s = 0; s < ss; s++) begin
                prs1 = ref_map[g[s].rs1];
                prs2 = ref_map[g[s].rs2];
                prd[s] = ref_free.pop_front();
                check("info", g[s], entry[s].info);
                check("rob_id", rob_bits'(ref_rob_id + rob_bits'(s)), entry[s].rob_id);
                check("prs1", prs1, entry[s].prs1);
                check("prs2", prs2, entry[s].prs2);
                check("prd", prd[s], entry[s].prd);
                check("rs1_ready", g[s].use_imm1 || !ref_busy[prs1], entry[s].rs1_ready);
                check("rs2_ready", g[s].use_imm2 || !ref_busy[prs2], entry[s].rs2_ready);
                // Producer matters only for a register operand still in flight
                if (!g[s].use_imm1 && ref_busy[prs1]) begin
                    check("rs1_source", ref_producer[prs1], entry[s].rs1_source);
                end
                if (!g[s].use_imm2 && ref_busy[prs2]) begin
                    check("rs2_source", ref_producer[prs2], entry[s].rs2_source);
                end
                if (g[s].rd != '0) begin
                    ref_map[g[s].rd] = prd[s];
                    ref_busy[prd[s]] = 1'b1;
                    ref_producer[prd[s]] = rob_bits'(ref_rob_id + rob_bits'(s));
                    set_now[prd[s]] = 1'b1;
                end
            end
            ref_rob_id = rob_bits'(ref_rob_id + rob_bits'(ss));
            entries_seen++;
        end
        // Set beats a clear on the same edge
        if (last_wb_valid && !set_now[last_wb_preg]) begin
            ref_busy[last_wb_preg] = 1'b0;
        end
        last_wb_valid = wb_valid;
        last_wb_preg = wb_preg;
        // Queue occupancy after the edge just passed
        if (last_inst_push) begin
            iq_count++;
        end
        if (entry_valid) begin
            iq_count--;
        end
        check("iq_full", iq_count == iq_depth, iq_full);
        last_inst_push = inst_push;
    endtask

    // Decide at the falling edge, drive on the rising edge
    task automatic run_cycle();
        inst_group_t g;
        logic [preg_bits-1:0] pick [ss];
        logic [preg_bits-1:0] p;
        logic push_i;
        logic push_f;
        logic rs_next;
        logic wb_next;
        logic free_next;
        int found;
        int start;
        @(negedge clk);
        track_outputs();
        push_i = 1'b0;
        push_f = 1'b0;
        found = 0;
        // Groups not yet dispatched include the one still on its way in
        if (groups_sent < inst_target && sent.size() < iq_depth &&
            (!random_on || draw(4) != 0)) begin
            g = make_group();
            sent.push_back(g);
            groups_sent++;
            push_i = 1'b1;
        end
        if (fill_on && fill_next < preg_count) begin
            for (int s = 0; s < ss; s++) begin
                pick[s] = preg_bits'(fill_next + s);
                ref_free.push_back(pick[s]);
            end
            fill_next += ss;
            push_f = 1'b1;
        end else if (recycle_on && ref_free.size() <= 2 * fl_depth - ss) begin
            // Return unmapped registers, starting at a random point
            start = int'(draw(preg_count - 1));
            for (int k = 0; k < preg_count - 1; k++) begin
                p = preg_bits'(1 + (start + k) % (preg_count - 1));
                if (found < ss && is_unused(p)) begin
                    pick[found] = p;
                    ref_free.push_back(p);
                    found++;
                end
            end
            push_f = (found == ss);
        end
        rs_next = random_on ? rs_full : 1'b0;
        if (random_on && draw(8) == 0) begin
            rs_next = !rs_full;
        end
        wb_next = random_on && (draw(2) == 0);
        p = preg_bits'(draw(preg_count));
        free_next = random_on && (draw(3) != 0);
        @(posedge clk);
        cycle_count++;
        inst_push <= push_i;
        if (push_i) begin
            inst_group <= g;
        end
        free_push <= push_f;
        for (int s = 0; s < ss; s++) begin
            if (push_f) begin
                free_pair[s] <= pick[s];
            end
        end
        rs_full <= rs_next;
        wb_valid <= wb_next;
        wb_preg <= p;
        rob_free <= free_next;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        inst_push = 1'b0;
        free_push = 1'b0;
        rs_full = 1'b0;
        wb_valid = 1'b0;
        rob_free = 1'b0;
        inst_group = '0;
        free_pair = '0;
        wb_preg = '0;
        rng = 32'd20;
        for (int i = 0; i < 32; i++) begin
            ref_map[i] = preg_bits'(i);
        end
        for (int i = 0; i < preg_count; i++) begin
            ref_busy[i] = 1'b0;
            ref_producer[i] = '0;
        end
        ref_rob_id = '0;
        last_wb_valid = 1'b0;
        last_wb_preg = '0;
        last_inst_push = 1'b0;
        iq_count = 0;
        groups_sent = 0;
        entries_seen = 0;
        inst_target = 0;
        fill_next = preg_count / 2;
        cycle_count = 0;
        fill_on = 1'b0;
        recycle_on = 1'b0;
        random_on = 1'b0;

        repeat (reset_cycles) run_cycle();
        rst <= 1'b0;

        // Groups waiting but no free registers
        inst_target = 2;
        repeat (10) run_cycle();
        check("idle without free registers", 0, entries_seen);

        // Fill 32 to 63, no ROB frees, so only four groups fit
        fill_on = 1'b1;
        inst_target = 6;
        repeat (30) run_cycle();
        check("rob stall entries", 4, entries_seen);

        // Random traffic with frees, writebacks and rs_full periods
        recycle_on = 1'b1;
        random_on = 1'b1;
        inst_target = group_total;
        while (entries_seen < group_total) begin
            run_cycle();
        end
        // Empty queue, nothing more may leave
        repeat (10) run_cycle();
        check("final entry count", group_total, entries_seen);
        $display("Everything OK");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles with the tests still running", watchdog_cycles);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule : rename_dispatch_tb

`default_nettype wire

/* list.f */
verilog/rename_pkg.sv
verilog/rename_if.sv
verilog/sync_fifo.sv
verilog/rename_table.sv
verilog/preg_status.sv
verilog/rob_id_alloc.sv
verilog/dispatcher.sv
verilog/rename_dispatch_top.sv
testbench/rename_dispatch_assertions.sv
testbench/rename_dispatch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal -j 0 --top-module rename_dispatch_tb \
        -o rename_dispatch_sim -f list.f &&
    ./obj_dir/rename_dispatch_sim | tee /dev/stderr | grep -x "Everything OK" > /dev/null &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
